/* flist.f */
rtl/opq_cfg_pkg.sv
rtl/opq_instr_pkg.sv
rtl/alu_pipe.sv
rtl/iter_mul_unit.sv
rtl/pending_ops_queue.sv
rtl/op_completion_top.sv
dv/op_completion_tb.sv

/* dv/op_completion_tb.sv */
// Self-checking testbench; stops at the first error, and every wait loop has its own timeout
`timescale 1ns/1ps

module op_completion_tb;
    import opq_cfg_pkg::*;
    import opq_instr_pkg::*;

    localparam int DISP_LIMIT  = 100;    // Cycles a dispatch may wait
    localparam int DRAIN_LIMIT = 400;    // Cycles to empty the scoreboard
    localparam int QUIET_CYC   = 50;     // Longer than any multiply

    logic      clk_i;
    logic      rstn_i;
    logic      flush_i;
    logic      dispatch_valid_i;
    dispatch_t dispatch_i;
    logic      dispatch_ready_o;
    tag_t      dispatch_tag_o;
    logic      retire_valid_o;
    retire_t   retire_o;
    logic      retire_ready_i;

    retire_t exp_q[$];                   // Expected retires, dispatch order
    retire_t exp_r;
    retire_t snap;
    string   test_name;
    tag_t    last_tag;
    logic    have_last;                  // Cleared on flush, tags restart
    int      waited;

    op_completion_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;      // 20 ns period
    end

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH [%s] %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            abort_run("value check failed");
        end
    endtask

    // Expected {data, status} straight from the op definitions
    function automatic logic [34:0] ref_calc(input op_e op, input data_t a, input data_t b);
        longint      sa;
        longint      sb;
        longint      wide;
        logic [63:0] prod;
        data_t       r;
        logic        ovf;
        sa   = $signed(a);
        sb   = $signed(b);
        prod = {32'd0, a} * {32'd0, b};
        ovf  = 1'b0;
        r    = '0;
        case (op)
            OP_ADD, OP_SUB: begin
                wide = (op == OP_ADD) ? sa + sb : sa - sb;
                r    = wide[31:0];
                ovf  = (wide != longint'($signed(r)));   // Does not fit in 32 signed
            end
            OP_MIN:  r = (sa < sb) ? a : b;
            OP_MAX:  r = (sa > sb) ? a : b;
            OP_MUL: begin
                r   = prod[31:0];
                ovf = (prod[63:32] != '0);
            end
            default: r = '0;
        endcase
        return {r, ovf, r[31], r == '0};                 // {data, ovf, neg, zero}
    endfunction

    // Called at a falling edge, returns at a falling edge
    task automatic send_op(input op_e op, input data_t a, input data_t b, output int wait_cyc);
        dispatch_t   d;
        retire_t     e;
        logic [34:0] r;
        d.op             = op;
        d.a              = a;
        d.b              = b;
        d.rd             = reg_idx_t'($urandom);
        d.dest           = dest_e'($urandom_range(0, 1));
        dispatch_i       = d;
        dispatch_valid_i = 1'b1;
        wait_cyc         = 0;
        @(posedge clk_i);
        while (!dispatch_ready_o) begin
            if (wait_cyc >= DISP_LIMIT) begin
                abort_run("dispatch_ready_o stayed low, dispatch timed out");
            end else begin
                wait_cyc++;
                @(posedge clk_i);
            end
        end
        r        = ref_calc(op, a, b);
        e.tag    = dispatch_tag_o;                       // Tag before this edge
        e.rd     = d.rd;
        e.dest   = d.dest;
        e.data   = r[34:3];
        e.status = r[2:0];
        exp_q.push_back(e);
        @(negedge clk_i);
        dispatch_valid_i = 1'b0;
    endtask

    task automatic send_rand_alu(input int n);
        for (int i = 0; i < n; i++) begin
            send_op(op_e'($urandom_range(0, 3)), $urandom, $urandom, waited);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk_i);
        while (exp_q.size() != 0) begin
            if (n >= DRAIN_LIMIT) begin
                abort_run("outstanding operations never retired");
            end else begin
                n++;
                @(negedge clk_i);
            end
        end
    endtask

    // Scoreboard compare on every retire handshake
    initial begin
        forever begin
            @(posedge clk_i);
            if (rstn_i && retire_valid_o && retire_ready_i) begin
                if (exp_q.size() == 0) begin
                    abort_run("retire handshake with no operation outstanding");
                end else begin
                    exp_r = exp_q.pop_front();
                    check("retire", exp_r, retire_o);
                    if (have_last) check("tag order", tag_t'(last_tag + 1), retire_o.tag);
                    last_tag  = retire_o.tag;
                    have_last = 1'b1;
                end
            end
        end
    end

    initial begin
        rstn_i           = 1'b0;
        flush_i          = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_i       = '0;
        retire_ready_i   = 1'b0;
        have_last        = 1'b0;
        last_tag         = '0;
        test_name        = "reset";
        void'($urandom(32'h8b84_3413));
        repeat (4) @(posedge clk_i);                     // Four rising edges in reset
        @(negedge clk_i);
        check("ready in reset", 0, dispatch_ready_o);
        rstn_i = 1'b1;
        @(negedge clk_i);
        check("retire_valid", 0, retire_valid_o);
        check("dispatch_ready", 1, dispatch_ready_o);
        check("dispatch_tag", 0, dispatch_tag_o);
        retire_ready_i = 1'b1;

        test_name = "alu";
        send_op(OP_ADD, 32'h7fff_ffff, 32'h1, waited);             // Positive overflow
        send_op(OP_ADD, 32'h8000_0000, 32'h8000_0000, waited);     // Negative overflow, zero
        send_op(OP_SUB, 32'h8000_0000, 32'h1, waited);
        send_op(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, waited);
        send_op(OP_ADD, 32'd5, 32'hffff_fffb, waited);             // Zero result
        send_op(OP_MIN, 32'hffff_ffff, 32'h1, waited);
        send_op(OP_MAX, 32'h8000_0000, 32'h7fff_ffff, waited);
        send_rand_alu(40);
        wait_drain();

        test_name = "mul";
        send_op(OP_MUL, $urandom, 32'h0, waited);
        send_op(OP_MUL, $urandom, 32'h1, waited);
        send_op(OP_MUL, 32'hffff_ffff, 32'hffff_ffff, waited);
        send_op(OP_MUL, 32'h0001_0000, 32'h0001_0000, waited);     // Low word zero, overflow
        for (int i = 0; i < 20; i++) begin
            send_op(OP_MUL, $urandom, $urandom >> $urandom_range(0, 31), waited);
        end
        wait_drain();

        test_name = "in order";
        send_op(OP_MUL, $urandom, 32'h8000_0001, waited);          // Longest multiply
        send_rand_alu(6);
        wait_drain();

        test_name = "back pressure";
        retire_ready_i = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            send_op(op_e'($urandom_range(0, 3)), $urandom, $urandom, waited);
            check("stall before full", 0, waited);
        end
        check("ready when full", 0, dispatch_ready_o);
        waited = 0;
        while (!retire_valid_o) begin
            if (waited >= DISP_LIMIT) begin
                abort_run("retire_valid_o never rose with a full queue");
            end else begin
                waited++;
                @(negedge clk_i);
            end
        end
        snap = retire_o;
        repeat (10) begin
            @(negedge clk_i);
            check("held retire", snap, retire_o);
            check("held valid", 1, retire_valid_o);
        end
        retire_ready_i = 1'b1;
        wait_drain();

        test_name = "flush";
        retire_ready_i = 1'b0;
        send_op(OP_MUL, $urandom, 32'hffff_ffff, waited);          // Still running at flush
        send_rand_alu(3);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        exp_q.delete();
        have_last = 1'b0;
        check("tag after flush", 0, dispatch_tag_o);
        retire_ready_i = 1'b1;
        repeat (QUIET_CYC) begin
            @(negedge clk_i);
            check("stale retire", 0, retire_valid_o);
        end
        send_rand_alu(4);
        send_op(OP_MUL, $urandom, $urandom, waited);
        send_op(OP_MUL, $urandom, $urandom >> 20, waited);
        wait_drain();

        $display("*** PASSED ***");
        $finish;
    end

endmodule : op_completion_tb

/* rtl/op_completion_top.sv */
// Completion stage top; latency varies per op, retire_valid_o marks when a result is ready
`timescale 1ns/1ps

module op_completion_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     flush_i,
    input  logic                     dispatch_valid_i,
    input  opq_instr_pkg::dispatch_t dispatch_i,
    output logic                     dispatch_ready_o,
    output opq_cfg_pkg::tag_t        dispatch_tag_o,
    output logic                     retire_valid_o,
    output opq_instr_pkg::retire_t   retire_o,
    input  logic                     retire_ready_i
);
    import opq_instr_pkg::*;

    logic    alu_issue_valid;
    logic    mul_issue_valid;
    issue_t  issue;              // Fanned out to both units
    logic    mul_busy;           // Only back-pressure on issue
    logic    alu_result_valid;
    result_t alu_result;
    logic    mul_result_valid;
    result_t mul_result;

    pending_ops_queue u_queue (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .flush_i            (flush_i),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_i         (dispatch_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .dispatch_tag_o     (dispatch_tag_o),
        .alu_issue_valid_o  (alu_issue_valid),
        .mul_issue_valid_o  (mul_issue_valid),
        .issue_o            (issue),
        .mul_busy_i         (mul_busy),
        .alu_result_valid_i (alu_result_valid),
        .alu_result_i       (alu_result),
        .mul_result_valid_i (mul_result_valid),
        .mul_result_i       (mul_result),
        .retire_valid_o     (retire_valid_o),
        .retire_o           (retire_o),
        .retire_ready_i     (retire_ready_i)
    );

    // Fixed two-cycle unit
    alu_pipe u_alu (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .issue_valid_i  (alu_issue_valid),
        .issue_i        (issue),
        .result_valid_o (alu_result_valid),
        .result_o       (alu_result)
    );

    // Variable latency unit
    iter_mul_unit u_mul (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .issue_valid_i  (mul_issue_valid),
        .issue_i        (issue),
        .busy_o         (mul_busy),
        .result_valid_o (mul_result_valid),
        .result_o       (mul_result)
    );

endmodule : op_completion_top

/* rtl/pending_ops_queue.sv */
// In-order completion queue; results are matched by tag, a result for an unknown tag is ignored
`timescale 1ns/1ps

module pending_ops_queue (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     flush_i,            // Empties queue, tag back to 0
    // Dispatch
    input  logic                     dispatch_valid_i,
    input  opq_instr_pkg::dispatch_t dispatch_i,
    output logic                     dispatch_ready_o,
    output opq_cfg_pkg::tag_t        dispatch_tag_o,     // Tag of next accepted op
    // Issue to units
    output logic                     alu_issue_valid_o,
    output logic                     mul_issue_valid_o,
    output opq_instr_pkg::issue_t    issue_o,            // Shared by both units
    input  logic                     mul_busy_i,
    // Results back
    input  logic                     alu_result_valid_i,
    input  opq_instr_pkg::result_t   alu_result_i,
    input  logic                     mul_result_valid_i,
    input  opq_instr_pkg::result_t   mul_result_i,
    // Retire
    output logic                     retire_valid_o,
    output opq_instr_pkg::retire_t   retire_o,
    input  logic                     retire_ready_i
);
    import opq_cfg_pkg::*;
    import opq_instr_pkg::*;

    // Entry table, retire layout plus a done bit
    retire_t                entry_q [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] done_q;

    ptr_t head_q;             // Oldest op
    ptr_t tail_q;             // Next free slot
    cnt_t cnt_q;              // Occupancy
    tag_t tag_q;              // Tag counter
    logic run_q;              // Low until first edge out of reset

    logic                   is_mul;
    logic                   accept;
    logic                   retire_fire;
    logic [NUM_ENTRIES-1:0] alu_hit;
    logic [NUM_ENTRIES-1:0] mul_hit;

    assign is_mul = (dispatch_i.op == OP_MUL);

    // Room left, and multiplier free for a multiply
    assign dispatch_ready_o = run_q && !flush_i && (cnt_q < cnt_t'(NUM_ENTRIES)) &&
                              !(is_mul && mul_busy_i);
    assign accept           = dispatch_valid_i && dispatch_ready_o;
    assign dispatch_tag_o   = tag_q;

    // Route by opcode, same cycle as accept
    assign alu_issue_valid_o = accept && !is_mul;
    assign mul_issue_valid_o = accept && is_mul;
    assign issue_o = '{op: dispatch_i.op, a: dispatch_i.a, b: dispatch_i.b, tag: tag_q};

    // Head can leave only once its result is in
    assign retire_valid_o = (cnt_q != '0) && done_q[head_q];
    assign retire_o       = entry_q[head_q];
    assign retire_fire    = retire_valid_o && retire_ready_i;

    // Tag search, in-flight tags are unique
    always_comb begin
        for (int j = 0; j < NUM_ENTRIES; j++) begin
            alu_hit[j] = alu_result_valid_i && (entry_q[j].tag == alu_result_i.tag);
            mul_hit[j] = mul_result_valid_i && (entry_q[j].tag == mul_result_i.tag);
        end
    end

    // Pointers, count, tag and done bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
            tag_q  <= '0;
            done_q <= '0;
            run_q  <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (flush_i) begin
                head_q <= '0;
                tail_q <= '0;
                cnt_q  <= '0;
                tag_q  <= '0;             // Numbering restarts
                done_q <= '0;
            end else begin
                head_q <= head_q + ptr_t'(retire_fire);
                tail_q <= tail_q + ptr_t'(accept);   // Wraps at NUM_ENTRIES
                cnt_q  <= cnt_q + cnt_t'(accept) - cnt_t'(retire_fire);
                tag_q  <= tag_q + tag_t'(accept);
                if (accept) done_q[tail_q] <= 1'b0;
                for (int j = 0; j < NUM_ENTRIES; j++) begin
                    if (alu_hit[j] || mul_hit[j]) done_q[j] <= 1'b1;
                end
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            entry_q[tail_q].tag  <= tag_q;
            entry_q[tail_q].rd   <= dispatch_i.rd;
            entry_q[tail_q].dest <= dispatch_i.dest;
        end
        for (int j = 0; j < NUM_ENTRIES; j++) begin
            // Both units may land in the same cycle, on different entries
            if (alu_hit[j]) begin
                entry_q[j].data   <= alu_result_i.data;
                entry_q[j].status <= alu_result_i.status;
            end
            if (mul_hit[j]) begin
                entry_q[j].data   <= mul_result_i.data;
                entry_q[j].status <= mul_result_i.status;
            end
        end
    end

endmodule : pending_ops_queue

/* rtl/iter_mul_unit.sv */
// Iterative unsigned multiplier, one op at a time; caller must hold off issue while busy_o is high
`timescale 1ns/1ps

module iter_mul_unit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,          // Aborts a running op
    input  logic                   issue_valid_i,
    input  opq_instr_pkg::issue_t  issue_i,
    output logic                   busy_o,
    output logic                   result_valid_o,   // One-cycle pulse
    output opq_instr_pkg::result_t result_o
);
    import opq_cfg_pkg::*;
    import opq_instr_pkg::*;

    mul_state_e              state_q;
    logic [2*DATA_W-1:0]     acc_q;       // Partial product
    logic [2*DATA_W-1:0]     mcand_q;     // Shifted multiplicand
    data_t                   mplier_q;    // Remaining multiplier bits
    tag_t                    tag_q;

    // Current step operands, taken from the issue port on the first bit
    logic                    step_en;
    logic                    first;
    logic [2*DATA_W-1:0]     cur_acc;
    logic [2*DATA_W-1:0]     cur_mcand;
    data_t                   cur_mplier;
    logic [2*DATA_W-1:0]     nxt_acc;
    logic                    last;
    status_t                 stat;

    assign busy_o  = (state_q == MUL_BUSY);
    assign first   = (state_q == MUL_IDLE);
    assign step_en = (first && issue_valid_i) || busy_o;

    always_comb begin
        cur_acc    = first ? '0                   : acc_q;
        cur_mcand  = first ? {{DATA_W{1'b0}}, issue_i.a} : mcand_q;
        cur_mplier = first ? issue_i.b            : mplier_q;
        nxt_acc    = cur_acc + (cur_mplier[0] ? cur_mcand : '0);  // Add if bit set
        last       = (cur_mplier[DATA_W-1:1] == '0);              // Early exit
        stat          = '0;
        stat[ST_ZERO] = (nxt_acc[DATA_W-1:0] == '0);
        stat[ST_NEG]  = nxt_acc[DATA_W-1];
        stat[ST_OVF]  = (nxt_acc[2*DATA_W-1:DATA_W] != '0);       // High word lost
    end

    // FSM and result pulse
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q        <= MUL_IDLE;
            result_valid_o <= 1'b0;
        end else if (flush_i) begin
            state_q        <= MUL_IDLE;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= step_en && last;
            if (step_en) state_q <= last ? MUL_IDLE : MUL_BUSY;
        end
    end

    // Datapath, one multiplier bit per cycle, LSB first
    always_ff @(posedge clk_i) begin
        if (step_en) begin
            acc_q    <= nxt_acc;
            mcand_q  <= cur_mcand << 1;
            mplier_q <= cur_mplier >> 1;
        end
        if (first && issue_valid_i) tag_q <= issue_i.tag;
        if (step_en && last) begin
            result_o.tag    <= first ? issue_i.tag : tag_q;
            result_o.data   <= nxt_acc[DATA_W-1:0];
            result_o.status <= stat;
        end
    end

endmodule : iter_mul_unit

/* rtl/alu_pipe.sv */
// Two-stage ALU, accepts one op per cycle with no stall; OP_MUL must never be issued here
`timescale 1ns/1ps

module alu_pipe (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,          // Drops both stages
    input  logic                   issue_valid_i,
    input  opq_instr_pkg::issue_t  issue_i,
    output logic                   result_valid_o,   // One-cycle pulse
    output opq_instr_pkg::result_t result_o
);
    import opq_cfg_pkg::*;
    import opq_instr_pkg::*;

    // Stage one registers
    logic    s1_valid_q;
    op_e     s1_op_q;
    data_t   s1_a_q;
    data_t   s1_b_q;
    tag_t    s1_tag_q;

    // Stage two combinational results
    data_t   sum;
    data_t   diff;
    data_t   res;
    logic    a_lt_b;
    logic    ovf;
    status_t stat;

    assign sum    = s1_a_q + s1_b_q;
    assign diff   = s1_a_q - s1_b_q;
    assign a_lt_b = $signed(s1_a_q) < $signed(s1_b_q);

    always_comb begin
        ovf = 1'b0;
        unique case (s1_op_q)
            OP_ADD: begin
                res = sum;
                // Same-sign inputs, sign flipped
                ovf = (s1_a_q[DATA_W-1] == s1_b_q[DATA_W-1]) &&
                      (sum[DATA_W-1] != s1_a_q[DATA_W-1]);
            end
            OP_SUB: begin
                res = diff;
                ovf = (s1_a_q[DATA_W-1] != s1_b_q[DATA_W-1]) &&
                      (diff[DATA_W-1] != s1_a_q[DATA_W-1]);
            end
            OP_MIN:  res = a_lt_b ? s1_a_q : s1_b_q;
            OP_MAX:  res = a_lt_b ? s1_b_q : s1_a_q;
            default: res = '0;                              // Multiply not routed here
        endcase
        stat          = '0;
        stat[ST_ZERO] = (res == '0);
        stat[ST_NEG]  = res[DATA_W-1];
        stat[ST_OVF]  = ovf;
    end

    // Stage valids
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q     <= 1'b0;
            result_valid_o <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q     <= 1'b0;   // Kill anything in flight
            result_valid_o <= 1'b0;
        end else begin
            s1_valid_q     <= issue_valid_i;
            result_valid_o <= s1_valid_q;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            s1_op_q  <= issue_i.op;
            s1_a_q   <= issue_i.a;
            s1_b_q   <= issue_i.b;
            s1_tag_q <= issue_i.tag;
        end
        if (s1_valid_q) result_o <= '{tag: s1_tag_q, data: res, status: stat};
    end

endmodule : alu_pipe

/* rtl/opq_instr_pkg.sv */
// Opcodes and inter-block structs; OP_MUL goes to the multiplier, everything else to the ALU pipe
package opq_instr_pkg;

    import opq_cfg_pkg::*;

    // Supported operations
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_MIN = 3'd2,   // Signed
        OP_MAX = 3'd3,   // Signed
        OP_MUL = 3'd4    // Unsigned, low word kept
    } op_e;

    // Write-back destination, both share the retire port
    typedef enum logic [0:0] {
        DEST_SCALAR = 1'b0,
        DEST_FP     = 1'b1
    } dest_e;

    // Multiplier FSM
    typedef enum logic [0:0] {
        MUL_IDLE = 1'b0,
        MUL_BUSY = 1'b1
    } mul_state_e;

    // What the outside hands us
    typedef struct packed {
        op_e      op;
        data_t    a;
        data_t    b;
        reg_idx_t rd;
        dest_e    dest;
    } dispatch_t;

    // Queue to execution units
    typedef struct packed {
        op_e   op;
        data_t a;
        data_t b;
        tag_t  tag;
    } issue_t;

    // Execution units back to queue
    typedef struct packed {
        tag_t    tag;
        data_t   data;
        status_t status;
    } result_t;

    // In-order write-back, also the queue entry layout
    typedef struct packed {
        tag_t     tag;
        reg_idx_t rd;
        dest_e    dest;
        data_t    data;
        status_t  status;
    } retire_t;

endpackage : opq_instr_pkg

/* rtl/opq_cfg_pkg.sv */
// Cluster sizes and widths; tags must stay wider than the queue pointer to remain unique in flight
package opq_cfg_pkg;

    // Queue geometry
    localparam int NUM_ENTRIES = 8;               // Pending-op slots
    localparam int PTR_W       = 3;               // log2(NUM_ENTRIES)
    localparam int CNT_W       = PTR_W + 1;       // Needs to hold NUM_ENTRIES itself
    localparam int TAG_W       = 5;               // 32 tags, wraps freely

    // Datapath
    localparam int DATA_W      = 32;              // Integer stand-in for FP data
    localparam int REG_W       = 5;               // Destination register index

    // Status word bit positions
    localparam int ST_ZERO     = 0;
    localparam int ST_NEG      = 1;
    localparam int ST_OVF      = 2;
    localparam int STATUS_W    = 3;

    typedef logic [DATA_W-1:0]   data_t;          // Operand or result
    typedef logic [TAG_W-1:0]    tag_t;           // Op identifier
    typedef logic [PTR_W-1:0]    ptr_t;           // Head / tail index
    typedef logic [CNT_W-1:0]    cnt_t;           // Occupancy
    typedef logic [REG_W-1:0]    reg_idx_t;       // rd
    typedef logic [STATUS_W-1:0] status_t;        // {ovf, neg, zero}

endpackage : opq_cfg_pkg
